//--- hw/gzip_settings.svh
`ifndef GZIP_SETTINGS_SVH
`define GZIP_SETTINGS_SVH

// Width of every bus word on the input and output side
`define GZ_WORD_W 32

// Each FIFO holds this many words and the pointers need this many bits
`define GZ_FIFO_DEPTH 16
`define GZ_FIFO_AW 4

// A field carries 1 to 32 bits so its size needs six bits
`define GZ_SIZE_W 6

// Reflected CRC32 polynomial as used by GZIP
`define GZ_CRC_POLY 32'hEDB8_8320
// Start value of the CRC register and the final xor mask
`define GZ_CRC_INIT 32'hFFFF_FFFF

`endif

//--- hw/gzip_pkg.sv
package gzip_pkg;

	// One input word seen either as a block header or as four data bytes
	typedef union packed {
		struct packed {
			logic [6:0]  rsvd_hi;  // Unused top bits
			logic        bfinal;   // Bit 24 marks the last block of the stream
			logic [7:0]  rsvd_lo;  // Unused
			logic [15:0] len;      // Number of data bytes that follow
		} hdr;
		logic [3:0][7:0] bytes;    // Byte 0 is the first in stream order
	} block_word_u;

endpackage

//--- hw/field_if.sv
`include "gzip_settings.svh"

// Bit fields on their way from the framer to the packer
interface field_if;
	logic                  valid;   // Field is offered
	logic                  last;    // Final field of the stream so the packer flushes after it
	logic [`GZ_SIZE_W-1:0] size;    // Bit count from 1 to 32
	logic [`GZ_WORD_W-1:0] data;    // Right aligned field bits
	logic                  accept;  // Packer has room this cycle

	modport framer (
		output valid, last, size, data,
		input  accept
	);

	modport packer (
		input  valid, last, size, data,
		output accept
	);
endinterface

//--- hw/word_fifo.sv
`include "gzip_settings.svh"

module word_fifo #(
	parameter int DEPTH = `GZ_FIFO_DEPTH
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  wr,
	input  logic [`GZ_WORD_W-1:0] data_in,
	input  logic                  rd,
	output logic [`GZ_WORD_W-1:0] data_out,
	output logic                  full,
	output logic                  empty,
	output logic                  credit
);
	localparam int aw = `GZ_FIFO_AW;

	logic [`GZ_WORD_W-1:0] mem [DEPTH];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [aw:0]   count;    // One extra bit so a full FIFO is told apart from an empty one
	logic do_wr;
	logic do_rd;

	assign full = (count == (aw + 1)'(DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr && !full;    // Writes into a full FIFO are dropped
	assign do_rd = rd && !empty;
	assign credit = do_rd;         // One slot given back per word taken
	assign data_out = mem[rd_ptr]; // Head word falls through

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == aw'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == aw'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;  // Both or neither leave the count alone
			endcase
		end
	end
endmodule

//--- hw/block_framer.sv
`include "gzip_settings.svh"

module block_framer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  empty,
	input  gzip_pkg::block_word_u head,
	input  logic [`GZ_WORD_W-1:0] crc,
	output logic                  pop,
	output logic                  byte_valid,
	output logic [7:0]            byte_data,
	output logic                  done,
	field_if.framer               fld
);
	localparam logic [2:0] st_idle   = 3'd0;
	localparam logic [2:0] st_header = 3'd1;
	localparam logic [2:0] st_len    = 3'd2;
	localparam logic [2:0] st_data   = 3'd3;
	localparam logic [2:0] st_crc    = 3'd4;
	localparam logic [2:0] st_isize  = 3'd5;
	localparam logic [2:0] st_finish = 3'd6;

	localparam logic [`GZ_SIZE_W-1:0] sz_byte = `GZ_SIZE_W'(8);
	localparam logic [`GZ_SIZE_W-1:0] sz_word = `GZ_SIZE_W'(32);

	logic [2:0]            state;
	logic                  bfinal_q;  // Current block is the last one
	logic [15:0]           len_q;     // LEN of the current block
	logic [15:0]           cnt_q;     // Data bytes sent so far in this block
	logic [1:0]            lane_q;    // Byte lane of the head word to send next
	logic [`GZ_WORD_W-1:0] isize_q;   // Running sum of all LEN values
	logic                  fire;
	logic                  last_byte;

	// ====================
	// Field offer

	always_comb begin
		fld.valid = 1'b0;
		fld.last = 1'b0;
		fld.size = sz_byte;
		fld.data = '0;
		case (state)
			st_header: begin
				// BFINAL sits in bit 0 and BTYPE 00 plus the padding to the byte are zeros
				fld.valid = 1'b1;
				fld.data = {{(`GZ_WORD_W - 1){1'b0}}, head.hdr.bfinal};
			end
			st_len: begin
				fld.valid = 1'b1;
				fld.size = sz_word;
				fld.data = {~len_q, len_q};  // LEN in the low half then NLEN
			end
			st_data: begin
				fld.valid = !empty;  // Stall until the next data word arrives
				fld.data = `GZ_WORD_W'(head.bytes[lane_q]);
			end
			st_crc: begin
				fld.valid = 1'b1;
				fld.size = sz_word;
				fld.data = crc;  // Already holds the last data byte here
			end
			st_isize: begin
				fld.valid = 1'b1;
				fld.last = 1'b1;  // Tells the packer to flush behind it
				fld.size = sz_word;
				fld.data = isize_q;
			end
			default: ;
		endcase
	end

	assign fire = fld.valid && fld.accept;
	assign last_byte = (cnt_q == len_q - 16'd1);  // Only looked at in the data state where LEN is nonzero

	// Data bytes go to the CRC in the same cycle the packer takes them
	assign byte_valid = fire && (state == st_data);
	assign byte_data = head.bytes[lane_q];

	// The header word goes once it is sent and a data word after lane 3 or the block's last byte
	assign pop = fire && ((state == st_header) ||
		((state == st_data) && ((lane_q == 2'd3) || last_byte)));

	// The packer holds accept low until its flush word is out
	assign done = (state == st_finish) && fld.accept;

	// ====================
	// Sequencing

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			bfinal_q <= 1'b0;
			len_q <= '0;
			cnt_q <= '0;
			lane_q <= '0;
			isize_q <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (!empty) begin
						state <= st_header;  // Head word is a block header
					end
				end
				st_header: begin
					if (fire) begin
						bfinal_q <= head.hdr.bfinal;
						len_q <= head.hdr.len;
						isize_q <= isize_q + `GZ_WORD_W'(head.hdr.len);  // Wraps modulo 2^32
						state <= st_len;
					end
				end
				st_len: begin
					if (fire) begin
						cnt_q <= '0;
						lane_q <= '0;  // Data always starts in byte 0 of a fresh word
						if (len_q == '0) begin
							state <= bfinal_q ? st_crc : st_idle;
						end else begin
							state <= st_data;
						end
					end
				end
				st_data: begin
					if (fire) begin
						cnt_q <= cnt_q + 1'b1;
						lane_q <= lane_q + 1'b1;
						if (last_byte) begin
							state <= bfinal_q ? st_crc : st_idle;
						end
					end
				end
				st_crc: begin
					if (fire) begin
						state <= st_isize;
					end
				end
				st_isize: begin
					if (fire) begin
						state <= st_finish;
					end
				end
				default: ;  // Finish holds until the next reset
			endcase
		end
	end
endmodule

//--- hw/crc32_engine.sv
`include "gzip_settings.svh"

module crc32_engine (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  byte_valid,
	input  logic [7:0]            byte_data,
	output logic [`GZ_WORD_W-1:0] crc
);
	logic [`GZ_WORD_W-1:0] crc_q;

	// Eight shift steps of the reflected CRC with the byte folded into the low bits
	function automatic logic [`GZ_WORD_W-1:0] crc_step(
		input logic [`GZ_WORD_W-1:0] c,
		input logic [7:0]            b
	);
		logic [`GZ_WORD_W-1:0] r;
		r = c ^ `GZ_WORD_W'(b);
		for (int i = 0; i < 8; i++) begin
			r = r[0] ? ((r >> 1) ^ `GZ_CRC_POLY) : (r >> 1);  // LSB out first
		end
		return r;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crc_q <= `GZ_CRC_INIT;
		end else if (byte_valid) begin
			crc_q <= crc_step(crc_q, byte_data);
		end
	end

	assign crc = crc_q ^ `GZ_CRC_INIT;  // Final inversion
endmodule

//--- hw/bit_packer.sv
`include "gzip_settings.svh"

module bit_packer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  credit,
	output logic                  push,
	output logic [`GZ_WORD_W-1:0] word,
	field_if.packer               fld
);
	localparam int acc_w = 2 * `GZ_WORD_W;
	localparam int fw = $clog2(acc_w) + 1;  // Fill counts 0 to 63
	localparam int cw = `GZ_FIFO_AW + 1;
	localparam logic [fw-1:0] word_bits = fw'(`GZ_WORD_W);

	logic [acc_w-1:0] acc;         // Bits above the fill are always zero
	logic [fw-1:0]    fill;
	logic [cw-1:0]    credits;     // Free slots in the output FIFO
	logic             flush_pend;  // Last field is in and the tail still waits
	logic             fire;
	logic             word_ready;
	logic [fw-1:0]    fill_after;
	logic [acc_w-1:0] acc_after;
	logic [acc_w-1:0] field_bits;

	// ====================
	// Word out and field in

	always_comb begin
		// A full word or the zero padded tail during a flush
		word_ready = (fill >= word_bits) || (flush_pend && (fill != '0));
		push = word_ready && (credits != '0);
		word = acc[`GZ_WORD_W-1:0];
		fld.accept = ((fill < word_bits) || push) && !flush_pend;
		fire = fld.valid && fld.accept;

		fill_after = fill;
		acc_after = acc;
		if (push) begin
			fill_after = (fill >= word_bits) ? fill - word_bits : '0;  // Tail push empties it
			acc_after = acc >> `GZ_WORD_W;
		end

		// Mask off anything the framer left above the field size
		field_bits = {{`GZ_WORD_W{1'b0}}, fld.data} &
			((acc_w'(1) << fld.size) - acc_w'(1));
	end

	// ====================
	// State

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
			fill <= '0;
			credits <= cw'(`GZ_FIFO_DEPTH);  // Output FIFO starts empty
			flush_pend <= 1'b0;
		end else begin
			// New field lands just above what stays after the push
			acc <= fire ? (acc_after | (field_bits << fill_after)) : acc_after;
			fill <= fire ? fill_after + fw'(fld.size) : fill_after;
			case ({push, credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: ;  // Spend and return cancel out
			endcase
			if (fire && fld.last) begin
				flush_pend <= 1'b1;
			end else if (push && (fill <= word_bits)) begin
				flush_pend <= 1'b0;  // This push drains the accumulator
			end
		end
	end
endmodule

//--- hw/gzip_stored_top.sv
`include "gzip_settings.svh"

module gzip_stored_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_wr,
	input  logic [`GZ_WORD_W-1:0] in_data,
	output logic                  in_full,
	input  logic                  out_rd,
	output logic [`GZ_WORD_W-1:0] out_data,
	output logic                  out_empty,
	output logic                  done
);
	import gzip_pkg::*;

	block_word_u           in_head;     // Head of the input FIFO
	logic                  in_empty;
	logic                  in_pop;
	logic [`GZ_WORD_W-1:0] crc;
	logic                  byte_valid;
	logic [7:0]            byte_data;
	logic                  push;
	logic [`GZ_WORD_W-1:0] push_word;
	logic                  out_credit;  // One pulse per word read out

	field_if fld ();

	word_fifo #(.DEPTH(`GZ_FIFO_DEPTH)) u_in_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr       (in_wr),
		.data_in  (in_data),
		.rd       (in_pop),
		.data_out (in_head),
		.full     (in_full),
		.empty    (in_empty),
		.credit   ()  // The framer reads by empty and pop
	);

	block_framer u_framer (
		.clk        (clk),
		.rst_n      (rst_n),
		.empty      (in_empty),
		.head       (in_head),
		.crc        (crc),
		.pop        (in_pop),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.done       (done),
		.fld        (fld.framer)
	);

	crc32_engine u_crc (
		.clk        (clk),
		.rst_n      (rst_n),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.crc        (crc)
	);

	bit_packer u_packer (
		.clk    (clk),
		.rst_n  (rst_n),
		.credit (out_credit),
		.push   (push),
		.word   (push_word),
		.fld    (fld.packer)
	);

	word_fifo #(.DEPTH(`GZ_FIFO_DEPTH)) u_out_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr       (push),       // Never full when pushed thanks to the credits
		.data_in  (push_word),
		.rd       (out_rd),
		.data_out (out_data),
		.full     (),
		.empty    (out_empty),
		.credit   (out_credit)
	);
endmodule

//--- bench/tb_gzip_stored.sv
`include "gzip_settings.svh"

module tb_gzip_stored;
	import gzip_pkg::*;

	logic                  clk;
	logic                  rst_n;
	logic                  in_wr;
	logic [`GZ_WORD_W-1:0] in_data;
	logic                  in_full;
	logic                  out_rd;
	logic [`GZ_WORD_W-1:0] out_data;
	logic                  out_empty;
	logic                  done;

	logic [15:0]           blk_len[$];    // LEN of each block in stream order
	logic                  blk_final[$];
	logic [7:0]            blk_bytes[$];  // Data bytes of all blocks back to back
	logic [`GZ_WORD_W-1:0] in_words[$];   // Header and data words as written
	logic [`GZ_WORD_W-1:0] exp_words[$];  // Expected output stream
	logic                  writer_busy;
	int                    cycles = 0;
	int                    cycle_limit = 2000;  // Grows by 20 cycles per input byte

	gzip_stored_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_wr     (in_wr),
		.in_data   (in_data),
		.in_full   (in_full),
		.out_rd    (out_rd),
		.out_data  (out_data),
		.out_empty (out_empty),
		.done      (done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ====================
	// Failure reporting and watchdog

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_word(input logic [`GZ_WORD_W-1:0] got, input logic [`GZ_WORD_W-1:0] exp,
			input int idx);
		if (got !== exp)
			fail_now($sformatf("ERROR at time %0t: word %0d is %h, expected %h", $time, idx, got, exp));
	endtask

	task automatic check_done(input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("ERROR at time %0t: done is %b, expected %b", $time, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp)
			fail_now($sformatf("ERROR at time %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit)
			fail_now("Timeout: the output stream did not complete within the cycle limit");
	end

	// ====================
	// Reference model

	// Reflected CRC32 over one byte, fed one bit at a time LSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		logic        fb;
		r = c;
		for (int i = 0; i < 8; i++) begin
			fb = r[0] ^ d[i];
			r = r >> 1;
			if (fb)
				r = r ^ `GZ_CRC_POLY;
		end
		return r;
	endfunction

	// Byte stream of all blocks plus trailer, packed LSB first into zero padded words
	function automatic void build_expected();
		logic [7:0]  s[$];
		logic [31:0] crc;
		logic [31:0] isize;
		logic [31:0] w;
		int          pos;
		crc = `GZ_CRC_INIT;
		isize = '0;
		pos = 0;
		exp_words.delete();
		foreach (blk_len[b]) begin
			s.push_back({7'd0, blk_final[b]});  // BFINAL then BTYPE 00 and padding
			s.push_back(blk_len[b][7:0]);
			s.push_back(blk_len[b][15:8]);
			s.push_back(~blk_len[b][7:0]);      // NLEN
			s.push_back(~blk_len[b][15:8]);
			for (int i = 0; i < int'(blk_len[b]); i++) begin
				s.push_back(blk_bytes[pos]);
				crc = crc_byte(crc, blk_bytes[pos]);
				pos++;
			end
			isize = isize + 32'(blk_len[b]);
		end
		crc = crc ^ `GZ_CRC_INIT;
		for (int i = 0; i < 4; i++)
			s.push_back(crc[8*i +: 8]);
		for (int i = 0; i < 4; i++)
			s.push_back(isize[8*i +: 8]);
		for (int i = 0; i < s.size(); i += 4) begin
			w = '0;
			for (int j = 0; j < 4; j++) begin
				if (i + j < s.size())
					w[8*j +: 8] = s[i + j];
			end
			exp_words.push_back(w);
		end
	endfunction

	// ====================
	// Stimulus

	task automatic new_case();
		blk_len.delete();
		blk_final.delete();
		blk_bytes.delete();
		in_words.delete();
	endtask

	// Header word then data words, unused bytes of the last word get junk
	task automatic add_block(input int len, input logic fin);
		block_word_u w;
		int          base;
		w = $urandom;  // Reserved header bits carry noise
		w.hdr.bfinal = fin;
		w.hdr.len = 16'(len);
		in_words.push_back(w);
		blk_len.push_back(16'(len));
		blk_final.push_back(fin);
		base = blk_bytes.size();
		for (int i = 0; i < len; i++)
			blk_bytes.push_back(8'($urandom));
		for (int k = 0; k < (len + 3) / 4; k++) begin
			for (int j = 0; j < 4; j++)
				w.bytes[j] = (4*k + j < len) ? blk_bytes[base + 4*k + j] : 8'($urandom);
			in_words.push_back(w);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		in_wr = 1'b0;
		out_rd = 1'b0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		check_flag(in_full, 1'b0, "in_full");
		check_flag(out_empty, 1'b1, "out_empty");
		check_done(done, 1'b0);
	endtask

	task automatic write_words();
		foreach (in_words[i]) begin
			@(negedge clk);
			while (in_full || (($urandom % 8) == 0)) begin  // Full FIFO or a random idle cycle
				in_wr = 1'b0;
				@(negedge clk);
			end
			in_wr = 1'b1;
			in_data = in_words[i];
		end
		@(negedge clk);
		in_wr = 1'b0;
		writer_busy = 1'b0;
	endtask

	// Blocks the output for hold cycles, then pops on random cycles and compares
	task automatic read_words(input int hold);
		int   got;
		logic saw_full;
		got = 0;
		saw_full = 1'b0;
		repeat (hold) begin
			@(negedge clk);
			if (in_full)
				saw_full = 1'b1;
		end
		if ((hold > 0) && !saw_full)
			fail_now("in_full never rose while the output side was blocked");
		while (got < exp_words.size()) begin
			@(negedge clk);
			out_rd = 1'b0;
			// Words are still owed here so done needs the flush word waiting in the FIFO
			if (writer_busy || out_empty)
				check_done(done, 1'b0);
			if (!out_empty && (($urandom % 4) != 0)) begin
				check_word(out_data, exp_words[got], got);
				got++;
				if (got == exp_words.size())
					check_done(done, 1'b1);
				out_rd = 1'b1;
			end
		end
		@(negedge clk);
		out_rd = 1'b0;
		repeat (20) begin  // No word beyond the expected count may show up
			@(negedge clk);
			check_flag(out_empty, 1'b1, "out_empty after the last word");
			check_done(done, 1'b1);
		end
	endtask

	task automatic run_case(input int hold);
		build_expected();
		cycle_limit += 20 * 4 * in_words.size();
		apply_reset();
		writer_busy = 1'b1;
		fork
			write_words();
			read_words(hold);
		join
	endtask

	// ====================
	// Test sequence

	initial begin
		rst_n = 1'b0;
		in_wr = 1'b0;
		in_data = '0;
		out_rd = 1'b0;
		writer_busy = 1'b0;
		void'($urandom(32'hf4e3_5268));

		new_case();  // One short final block
		add_block(5, 1'b1);
		run_case(0);

		new_case();  // Three random blocks in one stream
		add_block(1 + int'($urandom % 40), 1'b0);
		add_block(1 + int'($urandom % 40), 1'b0);
		add_block(1 + int'($urandom % 40), 1'b1);
		run_case(0);

		new_case();  // Partial last words before the next header
		add_block(6, 1'b0);
		add_block(9, 1'b1);
		run_case(0);

		new_case();  // Empty blocks, one of them final
		add_block(0, 1'b0);
		add_block(3, 1'b0);
		add_block(0, 1'b1);
		run_case(0);

		new_case();  // Long stream against a blocked output
		add_block(200, 1'b0);
		add_block(120, 1'b1);
		run_case(300);

		$display("sim passed");
		$finish;
	end
endmodule

//--- vlog.f
+incdir+hw
hw/gzip_pkg.sv
hw/field_if.sv
hw/word_fifo.sv
hw/block_framer.sv
hw/crc32_engine.sv
hw/bit_packer.sv
hw/gzip_stored_top.sv
bench/tb_gzip_stored.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_gzip_stored
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_gzip_stored)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
